//--- design/snake_display_pkg.sv
//----------------------------------------
// shared timing, geometry, widths, tile codes and palette
// for the snake tile-map display; use with scoped names
//----------------------------------------

package snake_display_pkg;

  //----------------------------------------
  // 640x480 timing, in 50 MHz clock cycles
  localparam int h_active      = 1280;
  localparam int h_front_porch = 32;
  localparam int h_sync        = 192;
  localparam int h_back_porch  = 96;
  localparam int h_total       = h_active + h_front_porch + h_sync + h_back_porch;

  // vertical timing in lines
  localparam int v_active      = 480;
  localparam int v_front_porch = 10;
  localparam int v_sync        = 2;
  localparam int v_back_porch  = 33;
  localparam int v_total       = v_active + v_front_porch + v_sync + v_back_porch;

  //----------------------------------------
  // tile map geometry
  localparam int map_cols     = 40;
  localparam int map_rows     = 30;
  // 16 pixel tiles, two counts per pixel across
  localparam int tile_h_shift = 5;
  localparam int tile_v_shift = 4;

  // bus word layout
  localparam int tiles_per_word  = 4;
  localparam int words_per_row   = 10;
  localparam int background_addr = 300;

  //----------------------------------------
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;
  typedef logic [5:0]  tile_col_t;
  typedef logic [4:0]  tile_row_t;
  typedef logic [7:0]  tile_code_t;
  typedef logic [8:0]  bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [15:0] rgb565_t;
  typedef logic [23:0] rgb_t;
  typedef logic [7:0]  channel_t;

  // tile codes, anything above tile_body draws as empty
  localparam tile_code_t tile_empty = 8'd0;
  localparam tile_code_t tile_apple = 8'd1;
  localparam tile_code_t tile_head  = 8'd2;
  localparam tile_code_t tile_body  = 8'd3;

  // palette
  localparam rgb565_t apple_color = 16'hf800;
  localparam rgb565_t head_color  = 16'h07e0;
  localparam rgb565_t body_color  = 16'h03e0;
  localparam rgb565_t wall_color  = 16'h8410;

endpackage

//--- design/tile_lookup_if.sv
//----------------------------------------
// tile map lookup from the renderer into the map storage
//----------------------------------------
`timescale 1ns/1ns

interface tile_lookup_if;

  snake_display_pkg::tile_col_t  tile_col;
  snake_display_pkg::tile_row_t  tile_row;
  // combinational from the stored map
  snake_display_pkg::tile_code_t tile_code;
  snake_display_pkg::rgb_t       background;

  modport renderer (output tile_col, output tile_row,
                    input tile_code, input background);

  modport map (input tile_col, input tile_row,
               output tile_code, output background);

endinterface

//--- design/video_timing.sv
//----------------------------------------
// 640x480 beam counters and sync, one pixel every other clock
//----------------------------------------
`timescale 1ns/1ns

module video_timing #(
  parameter int h_active      = snake_display_pkg::h_active,
  parameter int h_front_porch = snake_display_pkg::h_front_porch,
  parameter int h_sync        = snake_display_pkg::h_sync,
  parameter int h_back_porch  = snake_display_pkg::h_back_porch,
  parameter int v_active      = snake_display_pkg::v_active,
  parameter int v_front_porch = snake_display_pkg::v_front_porch,
  parameter int v_sync        = snake_display_pkg::v_sync,
  parameter int v_back_porch  = snake_display_pkg::v_back_porch
) (
  input  logic                        clk,
  input  logic                        reset,
  output snake_display_pkg::hcount_t  hcount,
  output snake_display_pkg::vcount_t  vcount,
  output logic                        display_enable,
  output logic                        hsync_n,
  output logic                        vsync_n,
  output logic                        pixel_clk
);

  localparam snake_display_pkg::hcount_t h_last =
    snake_display_pkg::hcount_t'(h_active + h_front_porch + h_sync + h_back_porch - 1);
  localparam snake_display_pkg::vcount_t v_last =
    snake_display_pkg::vcount_t'(v_active + v_front_porch + v_sync + v_back_porch - 1);

  // sync windows, first count inside and first count past
  localparam snake_display_pkg::hcount_t hs_first =
    snake_display_pkg::hcount_t'(h_active + h_front_porch);
  localparam snake_display_pkg::hcount_t hs_end =
    snake_display_pkg::hcount_t'(h_active + h_front_porch + h_sync);
  localparam snake_display_pkg::vcount_t vs_first =
    snake_display_pkg::vcount_t'(v_active + v_front_porch);
  localparam snake_display_pkg::vcount_t vs_end =
    snake_display_pkg::vcount_t'(v_active + v_front_porch + v_sync);

  logic end_of_line;
  logic end_of_frame;

  assign end_of_line  = (hcount == h_last);
  assign end_of_frame = (vcount == v_last);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  // line counter steps once per wrap of hcount
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      vcount <= end_of_frame ? '0 : vcount + 1'b1;
    end
  end

  assign hsync_n        = !(hcount >= hs_first && hcount < hs_end);
  assign vsync_n        = !(vcount >= vs_first && vcount < vs_end);
  assign display_enable = (hcount < h_active) && (vcount < v_active);
  assign pixel_clk      = hcount[0];

endmodule

//--- design/tile_map_regs.sv
//----------------------------------------
// bus write port for the tile map and background colour,
// with a combinational lookup port for the renderer
//----------------------------------------
`timescale 1ns/1ns

module tile_map_regs #(
  parameter int map_cols        = snake_display_pkg::map_cols,
  parameter int map_rows        = snake_display_pkg::map_rows,
  parameter int tiles_per_word  = snake_display_pkg::tiles_per_word,
  parameter int words_per_row   = snake_display_pkg::words_per_row,
  parameter int background_addr = snake_display_pkg::background_addr
) (
  input  logic                         clk,
  input  logic                         reset,
  input  snake_display_pkg::bus_data_t writedata,
  input  logic                         write,
  input  logic                         chipselect,
  input  snake_display_pkg::bus_addr_t address,
  tile_lookup_if.map                   lookup
);

  localparam int data_w = $bits(snake_display_pkg::bus_data_t);
  localparam int code_w = $bits(snake_display_pkg::tile_code_t);

  snake_display_pkg::tile_code_t map_mem [map_rows][map_cols];
  snake_display_pkg::rgb_t       background_q;

  snake_display_pkg::tile_row_t  addr_row;
  snake_display_pkg::tile_col_t  addr_col;
  logic                          map_write;
  logic                          bg_write;

  //----------------------------------------
  // address decode
  // word a covers row a/10, columns from 4*(a%10)
  assign addr_row  = snake_display_pkg::tile_row_t'(address / words_per_row);
  assign addr_col  = snake_display_pkg::tile_col_t'((address % words_per_row) * tiles_per_word);
  assign map_write = chipselect && write && (address < map_rows * words_per_row);
  assign bg_write  = chipselect && write && (address == background_addr);

  // top byte goes to the lowest column
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int r = 0; r < map_rows; r++) begin
        for (int c = 0; c < map_cols; c++) begin
          map_mem[r][c] <= snake_display_pkg::tile_empty;
        end
      end
    end else if (map_write) begin
      for (int i = 0; i < tiles_per_word; i++) begin
        map_mem[addr_row][addr_col + i] <= writedata[data_w - 1 - i * code_w -: code_w];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      background_q <= '0;
    end else if (bg_write) begin
      background_q <= writedata[23:0];
    end
  end

  //----------------------------------------
  // lookup, empty outside the map
  always_comb begin
    if (lookup.tile_col < map_cols && lookup.tile_row < map_rows) begin
      lookup.tile_code = map_mem[lookup.tile_row][lookup.tile_col];
    end else begin
      lookup.tile_code = snake_display_pkg::tile_empty;
    end
  end

  assign lookup.background = background_q;

endmodule

//--- design/tile_renderer.sv
//----------------------------------------
// two-stage pixel pipeline: tile lookup and wall test,
// then palette select; colour lags the beam by two clocks
//----------------------------------------
`timescale 1ns/1ns

module tile_renderer #(
  parameter int map_cols = snake_display_pkg::map_cols,
  parameter int map_rows = snake_display_pkg::map_rows
) (
  input  logic                        clk,
  input  logic                        reset,
  input  snake_display_pkg::hcount_t  hcount,
  input  snake_display_pkg::vcount_t  vcount,
  input  logic                        display_enable,
  tile_lookup_if.renderer             lookup,
  output snake_display_pkg::channel_t vga_r,
  output snake_display_pkg::channel_t vga_g,
  output snake_display_pkg::channel_t vga_b
);

  // border is two tiles thick, sides start below the top band
  localparam snake_display_pkg::tile_col_t right_first =
    snake_display_pkg::tile_col_t'(map_cols - 2);
  localparam snake_display_pkg::tile_col_t col_last =
    snake_display_pkg::tile_col_t'(map_cols - 1);
  localparam snake_display_pkg::tile_row_t bottom_first =
    snake_display_pkg::tile_row_t'(map_rows - 2);
  localparam snake_display_pkg::tile_row_t row_last =
    snake_display_pkg::tile_row_t'(map_rows - 1);

  snake_display_pkg::tile_col_t  col;
  snake_display_pkg::tile_row_t  row;
  logic                          wall_hit;

  snake_display_pkg::tile_code_t code_q;
  logic                          wall_q;
  logic                          enable_q;

  snake_display_pkg::rgb_t       pixel_rgb;
  snake_display_pkg::rgb_t       rgb_q;

  function automatic snake_display_pkg::rgb_t widen(input snake_display_pkg::rgb565_t c);
    return {c[15:11], 3'b000, c[10:5], 2'b00, c[4:0], 3'b000};
  endfunction

  //----------------------------------------
  // stage 1
  // rows past 31 wrap, but those lines are blanked
  assign col = snake_display_pkg::tile_col_t'(hcount >> snake_display_pkg::tile_h_shift);
  assign row = snake_display_pkg::tile_row_t'(vcount >> snake_display_pkg::tile_v_shift);

  assign lookup.tile_col = col;
  assign lookup.tile_row = row;

  assign wall_hit = (col <= 1 && row >= 4) ||
                    (col >= right_first && col <= col_last && row >= 4) ||
                    (row == 2 || row == 3) ||
                    (row >= bottom_first && row <= row_last);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      code_q   <= snake_display_pkg::tile_empty;
      wall_q   <= 1'b0;
      enable_q <= 1'b0;
    end else begin
      code_q   <= lookup.tile_code;
      wall_q   <= wall_hit;
      enable_q <= display_enable;
    end
  end

  //----------------------------------------
  // stage 2
  always_comb begin
    if (!enable_q) begin
      pixel_rgb = '0;
    end else begin
      case (code_q)
        snake_display_pkg::tile_apple: pixel_rgb = widen(snake_display_pkg::apple_color);
        snake_display_pkg::tile_head:  pixel_rgb = widen(snake_display_pkg::head_color);
        snake_display_pkg::tile_body:  pixel_rgb = widen(snake_display_pkg::body_color);
        // empty and unknown codes fall through to wall or background
        default: begin
          pixel_rgb = wall_q ? widen(snake_display_pkg::wall_color) : lookup.background;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rgb_q <= '0;
    end else begin
      rgb_q <= pixel_rgb;
    end
  end

  assign vga_r = rgb_q[23:16];
  assign vga_g = rgb_q[15:8];
  assign vga_b = rgb_q[7:0];

endmodule

//--- design/snake_display_top.sv
//----------------------------------------
// snake game tile display: bus write port in, VGA out
//----------------------------------------
`timescale 1ns/1ns

module snake_display_top #(
  parameter int h_active        = snake_display_pkg::h_active,
  parameter int h_front_porch   = snake_display_pkg::h_front_porch,
  parameter int h_sync          = snake_display_pkg::h_sync,
  parameter int h_back_porch    = snake_display_pkg::h_back_porch,
  parameter int v_active        = snake_display_pkg::v_active,
  parameter int v_front_porch   = snake_display_pkg::v_front_porch,
  parameter int v_sync          = snake_display_pkg::v_sync,
  parameter int v_back_porch    = snake_display_pkg::v_back_porch,
  parameter int map_cols        = snake_display_pkg::map_cols,
  parameter int map_rows        = snake_display_pkg::map_rows,
  parameter int tiles_per_word  = snake_display_pkg::tiles_per_word,
  parameter int words_per_row   = snake_display_pkg::words_per_row,
  parameter int background_addr = snake_display_pkg::background_addr
) (
  input  logic                         clk,
  input  logic                         reset,
  input  snake_display_pkg::bus_data_t writedata,
  input  logic                         write,
  input  logic                         chipselect,
  input  snake_display_pkg::bus_addr_t address,
  output snake_display_pkg::channel_t  vga_r,
  output snake_display_pkg::channel_t  vga_g,
  output snake_display_pkg::channel_t  vga_b,
  output logic                         vga_clk,
  output logic                         vga_hs,
  output logic                         vga_vs,
  output logic                         vga_blank_n,
  output logic                         vga_sync_n
);

  snake_display_pkg::hcount_t hcount;
  snake_display_pkg::vcount_t vcount;
  logic                       display_enable;

  tile_lookup_if lookup ();

  video_timing #(
    .h_active(h_active), .h_front_porch(h_front_porch),
    .h_sync(h_sync), .h_back_porch(h_back_porch),
    .v_active(v_active), .v_front_porch(v_front_porch),
    .v_sync(v_sync), .v_back_porch(v_back_porch)
  ) video_timing_inst (
    .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
    .display_enable(display_enable), .hsync_n(vga_hs), .vsync_n(vga_vs),
    .pixel_clk(vga_clk)
  );

  tile_map_regs #(
    .map_cols(map_cols), .map_rows(map_rows), .tiles_per_word(tiles_per_word),
    .words_per_row(words_per_row), .background_addr(background_addr)
  ) tile_map_regs_inst (
    .clk(clk), .reset(reset), .writedata(writedata), .write(write),
    .chipselect(chipselect), .address(address), .lookup(lookup.map)
  );

  tile_renderer #(.map_cols(map_cols), .map_rows(map_rows)) tile_renderer_inst (
    .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
    .display_enable(display_enable), .lookup(lookup.renderer),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
  );

  assign vga_blank_n = display_enable;
  // composite sync on green not used
  assign vga_sync_n  = 1'b0;

endmodule

//--- tests/snake_display_tb.sv
//----------------------------------------
// testbench for the snake tile display
// writes a table of tiles over the bus, then probes sync and pixels
//----------------------------------------
`timescale 1ns/1ns

module snake_display_tb;

  localparam int rows         = snake_display_pkg::map_rows;
  localparam int cols         = snake_display_pkg::map_cols;
  localparam int h_total      = snake_display_pkg::h_total;
  localparam int v_total      = snake_display_pkg::v_total;
  localparam int frame_cycles = h_total * v_total;
  // reset, sync frame, two probe phases, plus margin
  localparam int cycle_limit  = 4 * frame_cycles + 20000;
  localparam int num_probes   = 27;
  localparam logic [7:0] random_code = 8'hff;

  typedef struct packed {
    logic       phase;
    logic [5:0] col;
    logic [4:0] row;
    logic [7:0] code;
    logic [3:0] px;
    logic [3:0] py;
  } probe_t;

  logic                         clk;
  logic                         reset;
  snake_display_pkg::bus_data_t writedata;
  logic                         write;
  logic                         chipselect;
  snake_display_pkg::bus_addr_t address;
  snake_display_pkg::channel_t  vga_r;
  snake_display_pkg::channel_t  vga_g;
  snake_display_pkg::channel_t  vga_b;
  logic                         vga_clk;
  logic                         vga_hs;
  logic                         vga_vs;
  logic                         vga_blank_n;
  logic                         vga_sync_n;

  probe_t                  probes [num_probes];
  logic [7:0]              shadow [rows][cols];
  logic                    word_done [rows * snake_display_pkg::words_per_row];
  snake_display_pkg::rgb_t bg_color;
  int                      tb_h;
  int                      tb_v;
  int                      errors;
  int                      checks;
  int                      cycles;

  snake_display_top snake_display_top_inst (
    .clk(clk), .reset(reset), .writedata(writedata), .write(write),
    .chipselect(chipselect), .address(address),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_clk(vga_clk),
    .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
    .vga_sync_n(vga_sync_n)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: got %h, expected %h (h %0d, v %0d)", name, actual, expected,
               tb_h, tb_v);
    end
  endtask

  // one clock, then follow the beam counters
  task automatic step_cycle();
    @(posedge clk);
    #1;
    if (tb_h == h_total - 1) begin
      tb_h = 0;
      tb_v = (tb_v == v_total - 1) ? 0 : tb_v + 1;
    end else begin
      tb_h = tb_h + 1;
    end
  endtask

  task automatic bus_write(input int addr, input logic [31:0] data);
    chipselect = 1'b1;
    write      = 1'b1;
    address    = snake_display_pkg::bus_addr_t'(addr);
    writedata  = data;
    step_cycle();
    chipselect = 1'b0;
    write      = 1'b0;
  endtask

  task automatic wait_frame_start();
    step_cycle();
    while (!(tb_h == 0 && tb_v == 0)) begin
      step_cycle();
    end
  endtask

  // low bits of each channel filled with zeros
  function automatic snake_display_pkg::rgb_t rgb565_to_888(input logic [15:0] c);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = {c[15:11], 3'b000};
    g = {c[10:5], 2'b00};
    b = {c[4:0], 3'b000};
    return {r, g, b};
  endfunction

  function automatic bit in_border(input int col, input int row);
    return (col <= 1 && row >= 4) || (col >= 38 && row >= 4) ||
           (row == 2 || row == 3) || (row >= 28);
  endfunction

  function automatic snake_display_pkg::rgb_t expected_color(input logic [7:0] code,
                                                             input int col, input int row);
    if (code == 8'd1) begin
      return rgb565_to_888(snake_display_pkg::apple_color);
    end else if (code == 8'd2) begin
      return rgb565_to_888(snake_display_pkg::head_color);
    end else if (code == 8'd3) begin
      return rgb565_to_888(snake_display_pkg::body_color);
    end else if (in_border(col, row)) begin
      return rgb565_to_888(snake_display_pkg::wall_color);
    end
    return bg_color;
  endfunction

  task automatic check_sync_frame();
    int hs_lo;
    int vs_lo;
    int lag_h;
    logic active;
    snake_display_pkg::rgb_t exp;
    hs_lo = snake_display_pkg::h_active + snake_display_pkg::h_front_porch;
    vs_lo = snake_display_pkg::v_active + snake_display_pkg::v_front_porch;
    repeat (frame_cycles) begin
      active = (tb_h < snake_display_pkg::h_active) && (tb_v < snake_display_pkg::v_active);
      // colour trails the beam by two counts and is black in blanking
      lag_h = tb_h - 2;
      if (lag_h >= 0 && lag_h < snake_display_pkg::h_active &&
          tb_v < snake_display_pkg::v_active) begin
        exp = expected_color(shadow[tb_v / 16][lag_h / 32], lag_h / 32, tb_v / 16);
      end else begin
        exp = '0;
      end
      check_value("vga_hs", 32'(vga_hs),
                  32'(!(tb_h >= hs_lo && tb_h < hs_lo + snake_display_pkg::h_sync)));
      check_value("vga_vs", 32'(vga_vs),
                  32'(!(tb_v >= vs_lo && tb_v < vs_lo + snake_display_pkg::v_sync)));
      check_value("vga_blank_n", 32'(vga_blank_n), 32'(active));
      check_value("vga_clk", 32'(vga_clk), 32'(tb_h % 2));
      check_value("vga_r", 32'(vga_r), 32'(exp[23:16]));
      check_value("vga_g", 32'(vga_g), 32'(exp[15:8]));
      check_value("vga_b", 32'(vga_b), 32'(exp[7:0]));
      step_cycle();
    end
  endtask

  //----------------------------------------
  // probe table in raster order per phase
  // phase, col, row, code, pixel x and y inside the tile
  task automatic load_table();
    probes[0]  = '{1'b0, 6'd10, 5'd0,  8'h00, 4'd3,  4'd5};
    probes[1]  = '{1'b0, 6'd8,  5'd2,  8'h00, 4'd6,  4'd5};
    probes[2]  = '{1'b0, 6'd15, 5'd2,  8'h00, 4'd7,  4'd5};
    probes[3]  = '{1'b0, 6'd20, 5'd3,  8'h00, 4'd0,  4'd5};
    probes[4]  = '{1'b0, 6'd0,  5'd6,  8'h00, 4'd4,  4'd5};
    probes[5]  = '{1'b0, 6'd1,  5'd6,  8'h00, 4'd15, 4'd5};
    probes[6]  = '{1'b0, 6'd5,  5'd6,  8'h01, 4'd8,  4'd5};
    probes[7]  = '{1'b0, 6'd12, 5'd6,  8'h02, 4'd2,  4'd5};
    probes[8]  = '{1'b0, 6'd39, 5'd6,  8'h00, 4'd9,  4'd5};
    probes[9]  = '{1'b0, 6'd30, 5'd8,  8'h03, 4'd11, 4'd0};
    probes[10] = '{1'b0, 6'd7,  5'd10, random_code, 4'd5, 4'd9};
    probes[11] = '{1'b0, 6'd38, 5'd10, 8'h00, 4'd1,  4'd9};
    probes[12] = '{1'b0, 6'd18, 5'd12, 8'h00, 4'd6,  4'd12};
    probes[13] = '{1'b0, 6'd25, 5'd12, random_code, 4'd14, 4'd12};
    probes[14] = '{1'b0, 6'd20, 5'd15, 8'h03, 4'd8,  4'd8};
    probes[15] = '{1'b0, 6'd21, 5'd15, 8'h01, 4'd8,  4'd8};
    probes[16] = '{1'b0, 6'd22, 5'd15, 8'h02, 4'd8,  4'd8};
    probes[17] = '{1'b0, 6'd23, 5'd15, 8'h00, 4'd8,  4'd8};
    probes[18] = '{1'b0, 6'd1,  5'd20, 8'h00, 4'd3,  4'd3};
    probes[19] = '{1'b0, 6'd39, 5'd24, 8'h00, 4'd12, 4'd15};
    probes[20] = '{1'b0, 6'd16, 5'd28, 8'h00, 4'd5,  4'd1};
    probes[21] = '{1'b0, 6'd33, 5'd29, 8'h00, 4'd10, 4'd6};
    // border tiles that get a code in the second phase
    probes[22] = '{1'b1, 6'd8,  5'd2,  8'h01, 4'd6,  4'd5};
    probes[23] = '{1'b1, 6'd1,  5'd20, 8'h03, 4'd3,  4'd3};
    probes[24] = '{1'b1, 6'd39, 5'd24, 8'h02, 4'd12, 4'd15};
    probes[25] = '{1'b1, 6'd16, 5'd28, random_code, 4'd5, 4'd1};
    probes[26] = '{1'b1, 6'd33, 5'd29, 8'h02, 4'd10, 4'd6};
  endtask

  // update the shadow map, then write each touched word once
  task automatic write_phase(input logic phase);
    int addr;
    int base;
    int r;
    foreach (word_done[i]) word_done[i] = 1'b0;
    for (int i = 0; i < num_probes; i++) begin
      if (probes[i].phase == phase) begin
        shadow[probes[i].row][probes[i].col] = probes[i].code;
      end
    end
    for (int i = 0; i < num_probes; i++) begin
      r    = int'(probes[i].row);
      base = (int'(probes[i].col) / 4) * 4;
      addr = r * snake_display_pkg::words_per_row + base / 4;
      if (probes[i].phase == phase && !word_done[addr]) begin
        word_done[addr] = 1'b1;
        bus_write(addr, {shadow[r][base], shadow[r][base + 1], shadow[r][base + 2],
                         shadow[r][base + 3]});
      end
    end
  endtask

  // colour for the beam position appears two clocks later
  task automatic probe_pixel(input probe_t p);
    int th;
    int tv;
    snake_display_pkg::rgb_t exp;
    th = int'(p.col) * 32 + int'(p.px) * 2;
    tv = int'(p.row) * 16 + int'(p.py);
    while (!(tb_h == th && tb_v == tv)) begin
      step_cycle();
    end
    exp = expected_color(shadow[p.row][p.col], int'(p.col), int'(p.row));
    step_cycle();
    step_cycle();
    check_value("vga_r", 32'(vga_r), 32'(exp[23:16]));
    check_value("vga_g", 32'(vga_g), 32'(exp[15:8]));
    check_value("vga_b", 32'(vga_b), 32'(exp[7:0]));
  endtask

  //----------------------------------------
  initial begin
    reset      = 1'b1;
    writedata  = '0;
    write      = 1'b0;
    chipselect = 1'b0;
    address    = '0;
    errors     = 0;
    checks     = 0;
    tb_h       = 0;
    tb_v       = 0;
    bg_color   = '0;
    void'($urandom(32'ha739ea8c));
    foreach (shadow[r, c]) shadow[r][c] = 8'h00;
    load_table();
    // random codes above 3
    for (int i = 0; i < num_probes; i++) begin
      if (probes[i].code == random_code) begin
        probes[i].code = 8'(4 + ($urandom % 252));
      end
    end

    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    check_value("vga_r", 32'(vga_r), 32'h0);
    check_value("vga_g", 32'(vga_g), 32'h0);
    check_value("vga_b", 32'(vga_b), 32'h0);
    check_value("vga_hs", 32'(vga_hs), 32'h1);
    check_value("vga_vs", 32'(vga_vs), 32'h1);
    check_value("vga_sync_n", 32'(vga_sync_n), 32'h0);

    check_sync_frame();

    // top byte must be ignored
    bg_color = 24'h1a2b3c;
    bus_write(snake_display_pkg::background_addr, {8'hee, bg_color});

    for (int ph = 0; ph < 2; ph++) begin
      write_phase(ph[0]);
      wait_frame_start();
      for (int i = 0; i < num_probes; i++) begin
        if (probes[i].phase == ph[0]) begin
          probe_pixel(probes[i]);
        end
      end
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- src.f
design/snake_display_pkg.sv
design/tile_lookup_if.sv
design/video_timing.sv
design/tile_map_regs.sv
design/tile_renderer.sv
design/snake_display_top.sv
tests/snake_display_tb.sv

//--- Makefile
# Verilator build and run for the snake tile-map display

VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = snake_display_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_TEXT = ^PASS: all tests$$

SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
